/* logic/idu_pkg.sv */
// Decode stage shared types
`default_nettype none

package idu_pkg;

    localparam int INST_WIDTH      = 32;   // instruction word
    localparam int INST_ADDR_WIDTH = 32;   // pc width
    localparam int REG_ADDR_WIDTH  = 5;    // x0..x31
    localparam int BUS_ADDR_WIDTH  = 32;   // csr address as carried downstream
    localparam int CSR_ADDR_WIDTH  = 12;   // csr field in the word

    typedef logic [INST_WIDTH-1:0]      inst_word_t;
    typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;
    typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [BUS_ADDR_WIDTH-1:0]  bus_addr_t;
    typedef logic [31:0]                imm_t;      // sign extended immediate
    typedef logic [6:0]                 opcode_t;
    typedef logic [3:0]                 op_t;       // {inst[30], funct3} or a special code
    typedef logic [2:0]                 unit_t;     // execute unit select

    // execute unit codes
    localparam unit_t UNIT_NONE = 3'd0;
    localparam unit_t UNIT_ALU  = 3'd1;
    localparam unit_t UNIT_BJP  = 3'd2;    // branch and jump
    localparam unit_t UNIT_LSU  = 3'd3;
    localparam unit_t UNIT_CSR  = 3'd4;
    localparam unit_t UNIT_SYS  = 3'd5;    // ecall, ebreak, mret, fence

    // RV32I major opcodes
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    // op codes with no funct3 of their own, taken from unused alu/bjp slots
    localparam op_t OP_LUI   = 4'b1001;    // alu, result is imm
    localparam op_t OP_AUIPC = 4'b1010;    // alu, result is pc + imm
    localparam op_t OP_JAL   = 4'b1100;    // bjp, target pc + imm
    localparam op_t OP_JALR  = 4'b1101;    // bjp, target rs1 + imm

    typedef struct packed {
        unit_t unit;       // which execute unit takes it
        op_t   op;         // operation within the unit
        logic  src2_imm;   // operand 2 is the immediate
        logic  is_load;
        logic  is_store;
        logic  illegal;    // not an RV32I/Zicsr encoding
    } dec_info_t;

    // everything handed from decode to execute
    typedef struct packed {
        inst_addr_t inst_addr;
        logic       reg_we;
        reg_addr_t  reg_waddr;
        reg_addr_t  reg1_raddr;
        reg_addr_t  reg2_raddr;
        logic       csr_we;
        bus_addr_t  csr_waddr;
        bus_addr_t  csr_raddr;
        dec_info_t  dec_info;
        imm_t       dec_imm;
        logic       is_pred_branch;   // fetch predicted taken branch
        logic       is_pred_jalr;     // fetch predicted jalr target
        inst_addr_t branch_addr;      // predicted target
    } idex_bundle_t;

    localparam idex_bundle_t IDEX_BUBBLE = '0;   // all zero is a nop

    typedef struct packed {
        logic stall;   // hold the stage register
        logic flush;   // load a bubble
    } stage_ctrl_t;

endpackage

`default_nettype wire

/* logic/inst_decoder.sv */
// RV32I instruction decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire idu_pkg::inst_word_t   inst_i,            // word from fetch
    input  wire idu_pkg::inst_addr_t   inst_addr_i,       // its pc
    input  wire                        is_pred_branch_i,
    input  wire                        is_pred_jalr_i,
    input  wire idu_pkg::inst_addr_t   branch_addr_i,     // predicted target
    output idu_pkg::idex_bundle_t      bundle_o           // decoded, not yet registered
);
    import idu_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    imm_t       imm_i;
    imm_t       imm_s;
    imm_t       imm_b;
    imm_t       imm_u;
    imm_t       imm_j;
    imm_t       imm_z;
    bus_addr_t  csr_addr;
    dec_info_t  info;
    imm_t       imm;
    logic       wr_rd;      // format writes rd
    logic       use_rs1;    // format reads rs1
    logic       use_rs2;    // format reads rs2
    logic       csr_op;     // csrrw/s/c and immediate forms

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_z = {27'b0, inst_i[19:15]};   // csr uimm sits in rs1 field

    assign csr_addr = {{(BUS_ADDR_WIDTH-CSR_ADDR_WIDTH){1'b0}}, inst_i[31:20]};

    always_comb begin
        info      = '0;
        info.unit = UNIT_NONE;
        imm       = '0;
        wr_rd     = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        csr_op    = 1'b0;
        case (opcode)
            OPC_OP: begin                               // R type
                info.unit = UNIT_ALU;
                info.op   = {inst_i[30], funct3};       // bit 30 picks sub/sra
                wr_rd     = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            OPC_OP_IMM: begin
                info.unit     = UNIT_ALU;
                info.op       = {(funct3 == 3'b101) & inst_i[30], funct3};  // srai only
                info.src2_imm = 1'b1;
                imm           = imm_i;
                wr_rd         = 1'b1;
                use_rs1       = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                info.unit     = UNIT_ALU;
                info.op       = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                info.src2_imm = 1'b1;
                imm           = imm_u;
                wr_rd         = 1'b1;
            end
            OPC_JAL: begin
                info.unit     = UNIT_BJP;
                info.op       = OP_JAL;
                info.src2_imm = 1'b1;
                imm           = imm_j;
                wr_rd         = 1'b1;                   // link register
            end
            OPC_JALR: begin
                info.unit     = UNIT_BJP;
                info.op       = OP_JALR;
                info.src2_imm = 1'b1;
                imm           = imm_i;
                wr_rd         = 1'b1;
                use_rs1       = 1'b1;
            end
            OPC_BRANCH: begin
                info.unit = UNIT_BJP;
                info.op   = {1'b0, funct3};             // compare kind
                imm       = imm_b;                      // offset, operands are rs1/rs2
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
            end
            OPC_LOAD: begin
                info.unit     = UNIT_LSU;
                info.op       = {1'b0, funct3};         // size and sign
                info.src2_imm = 1'b1;
                info.is_load  = 1'b1;
                imm           = imm_i;
                wr_rd         = 1'b1;
                use_rs1       = 1'b1;
            end
            OPC_STORE: begin
                info.unit     = UNIT_LSU;
                info.op       = {1'b0, funct3};
                info.src2_imm = 1'b1;
                info.is_store = 1'b1;
                imm           = imm_s;
                use_rs1       = 1'b1;                   // base
                use_rs2       = 1'b1;                   // store data
            end
            OPC_MISC_MEM: begin
                info.unit = UNIT_SYS;
                info.op   = {1'b1, funct3};             // fence / fence.i
            end
            OPC_SYSTEM: begin
                if (funct3 == 3'b000) begin             // ecall, ebreak, mret
                    info.unit = UNIT_SYS;
                    imm       = imm_i;                  // funct12 tells them apart
                end else if (funct3 == 3'b100) begin
                    info.illegal = 1'b1;                // no csr op here
                end else begin
                    info.unit = UNIT_CSR;
                    info.op   = {1'b0, funct3};
                    csr_op    = 1'b1;
                    wr_rd     = 1'b1;                   // old csr value
                    if (funct3[2]) begin
                        info.src2_imm = 1'b1;
                        imm           = imm_z;
                    end else begin
                        use_rs1 = 1'b1;
                    end
                end
            end
            default: info.illegal = 1'b1;               // no enables set
        endcase
    end

    always_comb begin
        bundle_o                = '0;
        bundle_o.inst_addr      = inst_addr_i;
        bundle_o.reg_we         = wr_rd & (rd != '0);     // x0 never written
        bundle_o.reg_waddr      = wr_rd ? rd : '0;
        bundle_o.reg1_raddr     = use_rs1 ? rs1 : '0;     // unused sources read x0
        bundle_o.reg2_raddr     = use_rs2 ? rs2 : '0;
        // set/clear forms with a zero source field only read the csr
        bundle_o.csr_we         = csr_op & ~(funct3[1] & (rs1 == '0));
        bundle_o.csr_waddr      = csr_op ? csr_addr : '0;
        bundle_o.csr_raddr      = csr_op ? csr_addr : '0;
        bundle_o.dec_info       = info;
        bundle_o.dec_imm        = imm;
        bundle_o.is_pred_branch = is_pred_branch_i;
        bundle_o.is_pred_jalr   = is_pred_jalr_i;
        bundle_o.branch_addr    = branch_addr_i;
    end

endmodule

`default_nettype wire

/* logic/pipe_ctrl.sv */
// Decode stage stall and flush control
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire                         ex_busy_i,      // execute cannot take more
    input  wire                         ex_redirect_i,  // decode holds a wrong-path word
    input  wire idu_pkg::idex_bundle_t  next_i,         // bundle now in decode
    input  wire idu_pkg::idex_bundle_t  curr_i,         // bundle in the register
    output idu_pkg::stage_ctrl_t        ctrl_o,
    output logic                        if_hold_o       // fetch repeats its word
);
    import idu_pkg::*;

    logic rs1_hit;
    logic rs2_hit;
    logic load_use;

    // load in flight whose rd is read by decode. sources are compared even if
    // the format ignores them, a false hit only costs a bubble
    assign rs1_hit  = (curr_i.reg_waddr == next_i.reg1_raddr);
    assign rs2_hit  = (curr_i.reg_waddr == next_i.reg2_raddr);
    assign load_use = curr_i.dec_info.is_load & curr_i.reg_we
                    & (curr_i.reg_waddr != '0) & (rs1_hit | rs2_hit);

    always_comb begin
        ctrl_o    = '0;
        if_hold_o = 1'b0;
        if (ex_busy_i) begin
            ctrl_o.stall = 1'b1;        // keep register and fetch
            if_hold_o    = 1'b1;
        end else if (ex_redirect_i) begin
            ctrl_o.flush = 1'b1;        // drop decode, fetch moves on
        end else if (load_use) begin
            ctrl_o.flush = 1'b1;        // one bubble
            if_hold_o    = 1'b1;        // same word retried next cycle
        end
    end

endmodule

`default_nettype wire

/* logic/idu_id_pipe.sv */
// Decode to execute pipeline register
`timescale 1ns/1ps
`default_nettype none

module idu_id_pipe (
    input  wire                         clk,
    input  wire                         reset_i,    // sync, active high
    input  wire idu_pkg::stage_ctrl_t   ctrl_i,     // stall/flush from pipe_ctrl
    input  wire idu_pkg::idex_bundle_t  bundle_i,   // decoder output
    output idu_pkg::idex_bundle_t       bundle_o    // to execute
);
    import idu_pkg::*;

    idex_bundle_t bundle_d;     // value loaded when not stalled
    idex_bundle_t bundle_q;
    logic         update_en;

    assign update_en = ~ctrl_i.stall;                           // stall beats flush
    assign bundle_d  = ctrl_i.flush ? IDEX_BUBBLE : bundle_i;   // flush inserts a nop

    // whole bundle in one register, enables and payload together
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bundle_q <= IDEX_BUBBLE;    // no write enables out of reset
        end else if (update_en) begin
            bundle_q <= bundle_d;
        end
    end

    assign bundle_o = bundle_q;

endmodule

`default_nettype wire

/* logic/decode_slice_top.sv */
// Decode slice top level
`timescale 1ns/1ps
`default_nettype none

module decode_slice_top (
    input  wire                         clk,
    input  wire                         reset_i,
    // from fetch
    input  wire idu_pkg::inst_word_t    inst_i,
    input  wire idu_pkg::inst_addr_t    inst_addr_i,
    // from predictor
    input  wire                         is_pred_branch_i,
    input  wire                         is_pred_jalr_i,
    input  wire idu_pkg::inst_addr_t    branch_addr_i,
    // from execute
    input  wire                         ex_busy_i,
    input  wire                         ex_redirect_i,
    // outputs
    output idu_pkg::idex_bundle_t       id_ex_o,        // registered decode result
    output logic                        if_hold_o       // to fetch
);
    import idu_pkg::*;

    idex_bundle_t next_bundle;      // combinational decode
    idex_bundle_t curr_bundle;      // register output, fed back for hazards
    stage_ctrl_t  stage_ctrl;

    inst_decoder i_inst_decoder (
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .is_pred_branch_i (is_pred_branch_i),
        .is_pred_jalr_i   (is_pred_jalr_i),
        .branch_addr_i    (branch_addr_i),
        .bundle_o         (next_bundle)
    );

    pipe_ctrl i_pipe_ctrl (
        .ex_busy_i     (ex_busy_i),
        .ex_redirect_i (ex_redirect_i),
        .next_i        (next_bundle),
        .curr_i        (curr_bundle),
        .ctrl_o        (stage_ctrl),
        .if_hold_o     (if_hold_o)
    );

    idu_id_pipe i_idu_id_pipe (
        .clk      (clk),
        .reset_i  (reset_i),
        .ctrl_i   (stage_ctrl),
        .bundle_i (next_bundle),
        .bundle_o (curr_bundle)
    );

    assign id_ex_o = curr_bundle;

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);
    localparam int HALF_PERIOD  = 20;   // 40 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 reset_o = 1'b0;                  // released with the other inputs
    end

endmodule

`default_nettype wire

/* tb/decode_slice_tb.sv */
// Decode slice testbench
`timescale 1ns/1ps
`default_nettype none

module decode_slice_tb;
    import idu_pkg::*;

    localparam int         MAX_CYCLES = 2000;            // about 4x the stimulus
    localparam inst_word_t NOP_WORD   = 32'h0000_0013;   // addi x0, x0, 0

    logic         clk;
    logic         reset;
    inst_word_t   inst_i;
    inst_addr_t   inst_addr_i;
    logic         is_pred_branch_i;
    logic         is_pred_jalr_i;
    inst_addr_t   branch_addr_i;
    logic         ex_busy_i;
    logic         ex_redirect_i;
    idex_bundle_t id_ex_o;
    logic         if_hold_o;

    integer       seed        = 32'h9e7f_101c;
    inst_addr_t   pc          = 32'h0000_1000;
    reg_addr_t    last_load_rd = '0;     // rd of the last random load, 0 if none
    idex_bundle_t model_q     = '0;      // expected register content
    logic         model_valid = 1'b0;
    int           cycle_cnt   = 0;

    tb_clk_gen i_tb_clk_gen (.clk_o(clk), .reset_o(reset));

    decode_slice_top i_decode_slice_top (
        .clk              (clk),
        .reset_i          (reset),
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .is_pred_branch_i (is_pred_branch_i),
        .is_pred_jalr_i   (is_pred_jalr_i),
        .branch_addr_i    (branch_addr_i),
        .ex_busy_i        (ex_busy_i),
        .ex_redirect_i    (ex_redirect_i),
        .id_ex_o          (id_ex_o),
        .if_hold_o        (if_hold_o)
    );

    function automatic imm_t sign_extend(input logic [31:0] raw, input int width);
        imm_t mask;
        mask = ~32'd0 << width;
        return raw[width-1] ? (raw | mask) : (raw & ~mask);
    endfunction

    // expected bundle straight from the RV32I/Zicsr field layout
    function automatic idex_bundle_t ref_decode(input inst_word_t w, input inst_addr_t addr,
                                                input logic pb, input logic pj,
                                                input inst_addr_t tgt);
        idex_bundle_t b;
        opcode_t      opc;
        logic [2:0]   f3;
        logic         writes;
        logic         reads1;
        logic         reads2;
        logic         is_csr;
        opc    = w[6:0];
        f3     = w[14:12];
        b      = '0;
        writes = 1'b0;
        reads1 = 1'b0;
        reads2 = 1'b0;
        is_csr = 1'b0;
        case (opc)
            OPC_OP: begin
                b.dec_info.unit = UNIT_ALU;
                b.dec_info.op   = {w[30], f3};
                writes = 1'b1;
                reads1 = 1'b1;
                reads2 = 1'b1;
            end
            OPC_OP_IMM: begin
                b.dec_info.unit     = UNIT_ALU;
                b.dec_info.op       = (f3 == 3'd5) ? {w[30], f3} : {1'b0, f3};
                b.dec_info.src2_imm = 1'b1;
                b.dec_imm = sign_extend(w[31:20], 12);
                writes = 1'b1;
                reads1 = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                b.dec_info.unit     = UNIT_ALU;
                b.dec_info.op       = (opc == OPC_LUI) ? OP_LUI : OP_AUIPC;
                b.dec_info.src2_imm = 1'b1;
                b.dec_imm = {w[31:12], 12'h000};
                writes = 1'b1;
            end
            OPC_JAL: begin
                b.dec_info.unit     = UNIT_BJP;
                b.dec_info.op       = OP_JAL;
                b.dec_info.src2_imm = 1'b1;
                b.dec_imm = sign_extend({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                writes = 1'b1;
            end
            OPC_JALR: begin
                b.dec_info.unit     = UNIT_BJP;
                b.dec_info.op       = OP_JALR;
                b.dec_info.src2_imm = 1'b1;
                b.dec_imm = sign_extend(w[31:20], 12);
                writes = 1'b1;
                reads1 = 1'b1;
            end
            OPC_BRANCH: begin
                b.dec_info.unit = UNIT_BJP;
                b.dec_info.op   = {1'b0, f3};
                b.dec_imm = sign_extend({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                reads1 = 1'b1;
                reads2 = 1'b1;
            end
            OPC_LOAD: begin
                b.dec_info.unit     = UNIT_LSU;
                b.dec_info.op       = {1'b0, f3};
                b.dec_info.src2_imm = 1'b1;
                b.dec_info.is_load  = 1'b1;
                b.dec_imm = sign_extend(w[31:20], 12);
                writes = 1'b1;
                reads1 = 1'b1;
            end
            OPC_STORE: begin
                b.dec_info.unit     = UNIT_LSU;
                b.dec_info.op       = {1'b0, f3};
                b.dec_info.src2_imm = 1'b1;
                b.dec_info.is_store = 1'b1;
                b.dec_imm = sign_extend({w[31:25], w[11:7]}, 12);
                reads1 = 1'b1;
                reads2 = 1'b1;
            end
            OPC_MISC_MEM: begin
                b.dec_info.unit = UNIT_SYS;
                b.dec_info.op   = {1'b1, f3};
            end
            OPC_SYSTEM: begin
                if (f3 == 3'd0) begin                    // ecall, ebreak, mret
                    b.dec_info.unit = UNIT_SYS;
                    b.dec_imm = sign_extend(w[31:20], 12);
                end else if (f3 == 3'd4) begin
                    b.dec_info.illegal = 1'b1;
                end else begin
                    b.dec_info.unit = UNIT_CSR;
                    b.dec_info.op   = {1'b0, f3};
                    is_csr = 1'b1;
                    writes = 1'b1;
                    if (f3 >= 3'd5) begin                // uimm forms
                        b.dec_info.src2_imm = 1'b1;
                        b.dec_imm = {27'd0, w[19:15]};
                    end else begin
                        reads1 = 1'b1;
                    end
                end
            end
            default: b.dec_info.illegal = 1'b1;
        endcase
        b.inst_addr      = addr;
        b.reg_we         = writes && (w[11:7] != 5'd0);
        b.reg_waddr      = writes ? w[11:7] : 5'd0;
        b.reg1_raddr     = reads1 ? w[19:15] : 5'd0;
        b.reg2_raddr     = reads2 ? w[24:20] : 5'd0;
        if (is_csr) begin
            b.csr_raddr = {20'd0, w[31:20]};
            b.csr_waddr = {20'd0, w[31:20]};
            // set and clear with a zero source only read
            b.csr_we = !((f3 == 3'b010 || f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111)
                         && w[19:15] == 5'd0);
        end
        b.is_pred_branch = pb;
        b.is_pred_jalr   = pj;
        b.branch_addr    = tgt;
        return b;
    endfunction

    function automatic logic load_use(input idex_bundle_t held, input idex_bundle_t dec);
        return held.dec_info.is_load && held.reg_we && held.reg_waddr != 5'd0
            && (held.reg_waddr == dec.reg1_raddr || held.reg_waddr == dec.reg2_raddr);
    endfunction

    function automatic logic known_opcode(input opcode_t opc);
        case (opc)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
            OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bundle(input idex_bundle_t act, input idex_bundle_t exp,
                                input string name);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;                                      // drive point
    endtask

    task automatic drive_inst(input inst_word_t w);
        logic [31:0] r;
        r = $random(seed);
        inst_i           = w;
        inst_addr_i      = pc;
        is_pred_branch_i = r[0];
        is_pred_jalr_i   = r[1];
        branch_addr_i    = {r[31:2], 2'b00};
        pc               = pc + 32'd4;
    endtask

    // present a word and keep it there until fetch is released
    task automatic issue(input inst_word_t w);
        logic held;
        drive_inst(w);
        held = 1'b1;
        while (held) begin
            @(negedge clk);
            held = if_hold_o;
            step();
        end
    endtask

    task automatic make_legal(output inst_word_t w);
        int         sel;
        logic [2:0] f3;
        w   = $random(seed);
        sel = $unsigned($random(seed)) % 11;
        f3  = w[14:12];
        case (sel)
            0: begin
                w[6:0]   = OPC_OP;
                w[31:25] = {1'b0, w[30] & (f3 == 3'd0 || f3 == 3'd5), 5'd0};  // sub, sra
            end
            1: begin
                w[6:0] = OPC_OP_IMM;
                if (f3 == 3'd1 || f3 == 3'd5)
                    w[31:25] = {1'b0, w[30] & (f3 == 3'd5), 5'd0};            // shifts
            end
            2: w[6:0] = OPC_LUI;
            3: w[6:0] = OPC_AUIPC;
            4: w[6:0] = OPC_JAL;
            5: begin
                w[6:0]   = OPC_JALR;
                w[14:12] = 3'd0;
            end
            6: begin
                w[6:0] = OPC_BRANCH;
                if (f3[2:1] == 2'b01) w[14] = 1'b1;     // no funct3 2 or 3
            end
            7: begin
                w[6:0] = OPC_LOAD;
                if (f3 == 3'd3 || f3 >= 3'd6) w[14:12] = 3'd2;
            end
            8: begin
                w[6:0] = OPC_STORE;
                w[14]  = 1'b0;
                if (f3[1:0] == 2'b11) w[13] = 1'b0;     // sb, sh, sw
            end
            9: begin
                w[6:0]   = OPC_MISC_MEM;
                w[14:13] = 2'b00;
            end
            default: begin
                w[6:0] = OPC_SYSTEM;
                if (f3 == 3'd4) w[14:12] = 3'd1;
                if (f3 == 3'd0) w[31:7] = {11'd0, w[20], 13'd0};   // ecall or ebreak
            end
        endcase
        if (last_load_rd != 5'd0) begin             // keep clear of load-use
            if (w[19:15] == last_load_rd) w[15] = ~w[15];
            if (w[24:20] == last_load_rd) w[20] = ~w[20];
        end
        last_load_rd = (w[6:0] == OPC_LOAD) ? w[11:7] : 5'd0;
    endtask

    task automatic make_illegal(output inst_word_t w);
        w = $random(seed);
        if (($unsigned($random(seed)) % 5) == 0) begin
            w[6:0]   = OPC_SYSTEM;
            w[14:12] = 3'd4;                          // hole in the system space
        end else begin
            while (known_opcode(w[6:0])) w[6:0] = $random(seed);
        end
    endtask

    // one-entry model of the stage register
    always @(posedge clk) begin : model_update
        idex_bundle_t dec;
        dec = ref_decode(inst_i, inst_addr_i, is_pred_branch_i, is_pred_jalr_i, branch_addr_i);
        if (reset) begin
            model_q     = '0;
            model_valid = 1'b1;
        end else if (!ex_busy_i) begin               // busy holds
            if (ex_redirect_i || load_use(model_q, dec))
                model_q = '0;
            else
                model_q = dec;
        end
    end

    // outputs compared mid cycle
    always @(negedge clk) begin : compare
        idex_bundle_t dec;
        logic         exp_hold;
        if (model_valid) begin
            dec = ref_decode(inst_i, inst_addr_i, is_pred_branch_i, is_pred_jalr_i,
                             branch_addr_i);
            exp_hold = ex_busy_i || (!ex_redirect_i && load_use(model_q, dec));
            check_bundle(id_ex_o, model_q, "id_ex_o");
            check_bit(if_hold_o, exp_hold, "if_hold_o");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    initial begin : stimulus
        inst_word_t   w;
        idex_bundle_t snap;
        idex_bundle_t exp_b;
        reg_addr_t    rd;
        logic [31:0]  r;
        int           n;
        inst_i           = NOP_WORD;
        inst_addr_i      = '0;
        is_pred_branch_i = 1'b0;
        is_pred_jalr_i   = 1'b0;
        branch_addr_i    = '0;
        ex_busy_i        = 1'b0;
        ex_redirect_i    = 1'b0;
        wait (reset == 1'b0);
        @(negedge clk);
        check_bundle(id_ex_o, IDEX_BUBBLE, "id_ex_o after reset");
        check_bit(if_hold_o, 1'b0, "if_hold_o after reset");
        step();

        for (int i = 0; i < 300; i++) begin          // back to back legal words
            make_legal(w);
            issue(w);
        end

        for (int i = 0; i < 10; i++) begin           // back-pressure from execute
            make_legal(w);
            drive_inst(w);
            exp_b = ref_decode(w, inst_addr_i, is_pred_branch_i, is_pred_jalr_i, branch_addr_i);
            ex_busy_i = 1'b1;
            @(negedge clk);
            snap = id_ex_o;
            n = 1 + $unsigned($random(seed)) % 6;
            repeat (n) begin
                step();
                @(negedge clk);
                check_bundle(id_ex_o, snap, "id_ex_o under busy");
                check_bit(if_hold_o, 1'b1, "if_hold_o under busy");
            end
            step();
            ex_busy_i = 1'b0;
            step();                                  // held word issues here
            drive_inst(NOP_WORD);
            last_load_rd = 5'd0;
            @(negedge clk);
            check_bundle(id_ex_o, exp_b, "id_ex_o after busy");
            step();
        end

        for (int i = 0; i < 8; i++) begin            // load then dependent, last to x0
            n  = 1 + $unsigned($random(seed)) % 31;
            rd = (i == 7) ? 5'd0 : n[4:0];
            r  = $random(seed);
            issue({r[31:20], r[19:15], 3'b010, rd, OPC_LOAD});
            if (i % 2 == 0)
                w = {7'd0, r[24:20], rd, 3'b000, r[11:7], OPC_OP};
            else
                w = {7'd0, rd, r[24:20], 3'b000, r[11:7], OPC_OP};
            drive_inst(w);
            exp_b = ref_decode(w, inst_addr_i, is_pred_branch_i, is_pred_jalr_i, branch_addr_i);
            if (rd != 5'd0) begin
                @(negedge clk);
                check_bit(if_hold_o, 1'b1, "if_hold_o on load-use");
                step();
                @(negedge clk);
                check_bundle(id_ex_o, IDEX_BUBBLE, "id_ex_o on load-use");
            end else begin
                @(negedge clk);
            end
            check_bit(if_hold_o, 1'b0, "if_hold_o before dependent issue");
            step();
            drive_inst(NOP_WORD);
            @(negedge clk);
            check_bundle(id_ex_o, exp_b, "id_ex_o dependent");
            step();
        end

        for (int i = 0; i < 10; i++) begin           // redirect, odd passes also busy
            make_legal(w);
            drive_inst(w);
            ex_redirect_i = 1'b1;
            ex_busy_i     = (i % 2 == 1);
            @(negedge clk);
            snap = id_ex_o;
            step();
            ex_busy_i = 1'b0;
            if (i % 2 == 1) begin
                @(negedge clk);
                check_bundle(id_ex_o, snap, "id_ex_o stalled with redirect");
                step();
            end
            ex_redirect_i = 1'b0;
            drive_inst(NOP_WORD);
            last_load_rd = 5'd0;
            @(negedge clk);
            check_bundle(id_ex_o, IDEX_BUBBLE, "id_ex_o after redirect");
            step();
        end

        for (int i = 0; i < 30; i++) begin           // unknown encodings
            make_illegal(w);
            issue(w);
            @(negedge clk);
            check_bit(id_ex_o.dec_info.illegal, 1'b1, "id_ex_o.dec_info.illegal");
            check_bit(id_ex_o.reg_we, 1'b0, "id_ex_o.reg_we");
            check_bit(id_ex_o.csr_we, 1'b0, "id_ex_o.csr_we");
            step();
        end

        drive_inst(NOP_WORD);
        repeat (3) step();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* decode_slice.f */
logic/idu_pkg.sv
logic/inst_decoder.sv
logic/pipe_ctrl.sv
logic/idu_id_pipe.sv
logic/decode_slice_top.sv
tb/tb_clk_gen.sv
tb/decode_slice_tb.sv

/* Bender.yml */
package:
  name: decode_slice

sources:
  - logic/idu_pkg.sv
  - logic/inst_decoder.sv
  - logic/pipe_ctrl.sv
  - logic/idu_id_pipe.sv
  - logic/decode_slice_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/decode_slice_tb.sv
